// File: logic/router_config.svh
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// Input ports L, N, E, W, S
`define ROUTER_NUM_PORTS 5

`define ROUTER_DATA_WIDTH 16

// Hold length sits in the low bits of header data
`define ROUTER_LEN_WIDTH 12

`define ROUTER_ID_WIDTH 3

// Entries per input FIFO
`define ROUTER_FIFO_DEPTH 4

`endif

// File: logic/routerPkg.sv
`default_nettype none
`include "router_config.svh"

package routerPkg;

  // Local 0, North 1, East 2, West 3, South 4
  typedef logic [$clog2(`ROUTER_NUM_PORTS)-1:0] portIdxT;

  localparam logic [`ROUTER_ID_WIDTH-1:0] FLIT_HEADER = 3'd1; // Carries hold length
  localparam logic [`ROUTER_ID_WIDTH-1:0] FLIT_BODY   = 3'd2;
  localparam logic [`ROUTER_ID_WIDTH-1:0] FLIT_TAIL   = 3'd3;

  typedef struct packed {
    logic [`ROUTER_ID_WIDTH-1:0]   id;
    logic [`ROUTER_DATA_WIDTH-1:0] data;
  } flitT;

endpackage

`default_nettype wire

// File: logic/flitFifo.sv
`default_nettype none
`include "router_config.svh"

module flitFifo
(
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            inValid,
  output logic                 inReady,
  input  wire routerPkg::flitT inFlit,
  output logic                 headValid,
  output routerPkg::flitT      headFlit,
  input  wire logic            pop
);

  localparam int Depth = `ROUTER_FIFO_DEPTH;
  localparam int PtrWidth = $clog2(Depth);

  routerPkg::flitT     mem [Depth];
  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [PtrWidth:0]   count;
  logic                push;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign inReady   = (count != (PtrWidth + 1)'(Depth)); // Not full
  assign headValid = (count != '0);
  assign push      = inValid && inReady;
  assign headFlit  = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  // The top level only pops a FIFO that shows a head flit
  assert property (@(posedge clk) disable iff (rst) pop |-> headValid)
    else $error("flitFifo: pop while empty");

endmodule

`default_nettype wire

// File: logic/holdTimer.sv
`default_nettype none
`include "router_config.svh"

module holdTimer
(
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         loadEn,
  input  wire logic [`ROUTER_LEN_WIDTH-1:0] length,
  input  wire logic                         run,
  output logic                              timesUp
);

  logic [`ROUTER_LEN_WIDTH-1:0] limit;
  logic [`ROUTER_LEN_WIDTH-1:0] count; // Cycles of held grant

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (loadEn)
        limit <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // Length k gives k+1 cycles of grant
  assign timesUp = (count == limit);

endmodule

`default_nettype wire

// File: logic/outputArbiter.sv
`default_nettype none
`include "router_config.svh"

module outputArbiter
(
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [`ROUTER_NUM_PORTS-1:0]  req,
  input  wire logic [`ROUTER_ID_WIDTH-1:0]   headFlitId [`ROUTER_NUM_PORTS],
  input  wire logic [`ROUTER_LEN_WIDTH-1:0]  headLength [`ROUTER_NUM_PORTS],
  output logic [`ROUTER_NUM_PORTS-1:0]       grant,
  output routerPkg::portIdxT                 grantPort
);

  localparam int NumPorts = `ROUTER_NUM_PORTS;
  localparam logic [NumPorts:0] Idle = 1;

  // Bit 0 is idle, bit p+1 grants port p
  logic [NumPorts:0]   state;
  logic [NumPorts:0]   nextState;
  logic [NumPorts-1:0] isHeader;
  logic [NumPorts-1:0] loadEn;
  logic [NumPorts-1:0] runTimer;
  logic [NumPorts-1:0] timesUp;

  for (genvar p = 0; p < NumPorts; p++)
  begin : gTimer
    assign isHeader[p] = (headFlitId[p] == routerPkg::FLIT_HEADER);

    holdTimer i_timer
    (
      .clk     (clk),
      .rst     (rst),
      .loadEn  (loadEn[p]),
      .length  (headLength[p]),
      .run     (runTimer[p]),
      .timesUp (timesUp[p])
    );
  end

  assign grant    = state[NumPorts:1];
  assign loadEn   = ~grant & isHeader; // Limit frozen while granted
  assign runTimer = grant & req & ~timesUp; // Nonzero only when the grant holds

  always_comb
  begin
    grantPort = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
        grantPort = routerPkg::portIdxT'(i);
    end
  end

  always_comb
  begin
    int startIdx;
    int idx;
    logic found;
    // Search starts after the holder, so the holder comes last
    startIdx = state[0] ? 0 : int'(grantPort) + 1;
    found = 1'b0;
    idx = 0;
    nextState = Idle;
    if (|runTimer)
      nextState = state;
    else
    begin
      for (int k = 0; k < NumPorts; k++)
      begin
        idx = startIdx + k;
        if (idx >= NumPorts)
          idx = idx - NumPorts;
        if (!found && req[idx])
        begin
          nextState = '0;
          nextState[idx + 1] = 1'b1;
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= Idle;
    else
      state <= nextState;
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("outputArbiter: state not one-hot");

  // Every grant, new or held, was requested the cycle before
  assert property (@(posedge clk) disable iff (rst) 1'b1 |=> ((grant & ~$past(req)) == '0))
    else $error("outputArbiter: grant without request");

endmodule

`default_nettype wire

// File: logic/outputPort.sv
`default_nettype none
`include "router_config.svh"

module outputPort
(
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [`ROUTER_NUM_PORTS-1:0]  inValid,
  output logic [`ROUTER_NUM_PORTS-1:0]       inReady,
  input  wire logic [`ROUTER_ID_WIDTH-1:0]   inFlitId [`ROUTER_NUM_PORTS],
  input  wire logic [`ROUTER_DATA_WIDTH-1:0] inData [`ROUTER_NUM_PORTS],
  output logic                               outValid,
  input  wire logic                          outReady,
  output logic [`ROUTER_ID_WIDTH-1:0]        outFlitId,
  output logic [`ROUTER_DATA_WIDTH-1:0]      outData,
  output routerPkg::portIdxT                 outPort
);

  localparam int NumPorts = `ROUTER_NUM_PORTS;

  routerPkg::flitT              inFlit     [NumPorts];
  routerPkg::flitT              headFlit   [NumPorts];
  logic [`ROUTER_ID_WIDTH-1:0]  headFlitId [NumPorts];
  logic [`ROUTER_LEN_WIDTH-1:0] headLength [NumPorts];
  logic [NumPorts-1:0]          headValid;
  logic [NumPorts-1:0]          pop;
  logic [NumPorts-1:0]          grant;
  routerPkg::portIdxT           grantPort;
  routerPkg::flitT              selFlit;
  logic                         xfer;

  for (genvar p = 0; p < NumPorts; p++)
  begin : gPort
    assign inFlit[p] = '{id: inFlitId[p], data: inData[p]};

    flitFifo i_fifo
    (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[p]),
      .inReady   (inReady[p]),
      .inFlit    (inFlit[p]),
      .headValid (headValid[p]),
      .headFlit  (headFlit[p]),
      .pop       (pop[p])
    );

    assign headFlitId[p] = headFlit[p].id;
    assign headLength[p] = headFlit[p].data[`ROUTER_LEN_WIDTH-1:0]; // Only meaningful on headers
  end

  outputArbiter i_arbiter
  (
    .clk        (clk),
    .rst        (rst),
    .req        (headValid),
    .headFlitId (headFlitId),
    .headLength (headLength),
    .grant      (grant),
    .grantPort  (grantPort)
  );

  assign selFlit   = headFlit[grantPort];
  assign outValid  = |(grant & headValid);
  assign outFlitId = selFlit.id;
  assign outData   = selFlit.data;
  assign outPort   = grantPort;

  assign xfer = outValid && outReady;
  assign pop  = grant & {NumPorts{xfer}}; // Pop the owner on handshake

endmodule

`default_nettype wire

// File: verif/outputPortTb.sv
`default_nettype none
`include "router_config.svh"

module outputPortTb;

  localparam int NumPorts = `ROUTER_NUM_PORTS;
  localparam int NumTests = 6;
  localparam int MaxFlits = 8;
  localparam int Depth = `ROUTER_FIFO_DEPTH;
  localparam int FlitWidth = `ROUTER_ID_WIDTH + `ROUTER_DATA_WIDTH;

  logic                          clk = 1'b0;
  logic                          rst;
  logic [NumPorts-1:0]           inValid;
  logic [NumPorts-1:0]           inReady;
  logic [`ROUTER_ID_WIDTH-1:0]   inFlitId [NumPorts];
  logic [`ROUTER_DATA_WIDTH-1:0] inData [NumPorts];
  logic                          outValid;
  logic                          outReady;
  logic [`ROUTER_ID_WIDTH-1:0]   outFlitId;
  logic [`ROUTER_DATA_WIDTH-1:0] outData;
  routerPkg::portIdxT            outPort;

  // One row per test, ports in order L, N, E, W, S
  string testName [NumTests] = '{"passThrough", "fixedPriority", "rotation", "grantHold",
                                 "backPressure", "inputFlow"};
  int flitCount [NumTests][NumPorts] = '{'{4, 0, 0, 0, 0}, '{1, 1, 1, 1, 1},
                                         '{3, 3, 3, 3, 3}, '{4, 2, 0, 0, 0},
                                         '{3, 3, 3, 3, 3}, '{0, 0, 0, 5, 0}};
  int holdLen [NumTests][NumPorts] = '{'{3, 0, 0, 0, 0}, '{0, 0, 0, 0, 0},
                                       '{0, 0, 0, 0, 0}, '{2, 0, 0, 0, 0},
                                       '{0, 0, 0, 0, 0}, '{0, 0, 0, 1, 0}};
  bit allHeaders [NumTests] = '{0, 1, 1, 0, 1, 0}; // Else header, bodies, tail
  int readyMode [NumTests] = '{0, 0, 0, 0, 1, 2}; // 1 alternates, 2 starts low
  string expOrder [NumTests] = '{"0000", "01234", "012340123401234", "000101", "", "33333"};

  logic [FlitWidth-1:0]          flits [NumPorts][MaxFlits];
  int                            sent [NumPorts];
  int                            recvd [NumPorts];
  int                            occ [NumPorts]; // Model of FIFO fill
  logic [31:0]                   lcgState = 32'd20343;
  int                            errors = 0;
  int                            orderPos;
  int                            rowCycle;
  logic                          prevStall;
  routerPkg::portIdxT            prevPort;
  logic [FlitWidth-1:0]          prevFlit;

  outputPort i_outputPort
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inReady   (inReady),
    .inFlitId  (inFlitId),
    .inData    (inData),
    .outValid  (outValid),
    .outReady  (outReady),
    .outFlitId (outFlitId),
    .outData   (outData),
    .outPort   (outPort)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic bit allDone(input int r);
    bit done;
    done = 1'b1;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (sent[p] < flitCount[r][p] || recvd[p] < flitCount[r][p])
        done = 1'b0;
    end
    return done;
  endfunction

  task automatic buildFlits(input int r);
    logic [`ROUTER_ID_WIDTH-1:0]   id;
    logic [`ROUTER_DATA_WIDTH-1:0] data;
    for (int p = 0; p < NumPorts; p++)
    begin
      for (int i = 0; i < flitCount[r][p]; i++)
      begin
        lcgState = lcgNext(lcgState);
        data = lcgState[31:16];
        if (allHeaders[r] || i == 0)
        begin
          id = routerPkg::FLIT_HEADER;
          data[`ROUTER_LEN_WIDTH-1:0] = holdLen[r][p][`ROUTER_LEN_WIDTH-1:0]; // Hold length
        end
        else if (i == flitCount[r][p] - 1)
          id = routerPkg::FLIT_TAIL;
        else
          id = routerPkg::FLIT_BODY;
        flits[p][i] = {id, data};
      end
      sent[p] = 0;
      recvd[p] = 0;
      occ[p] = 0;
    end
  endtask

  task automatic driveInputs(input int r);
    for (int p = 0; p < NumPorts; p++)
    begin
      inValid[p] = (sent[p] < flitCount[r][p]);
      if (inValid[p])
        {inFlitId[p], inData[p]} = flits[p][sent[p]];
    end
    case (readyMode[r])
      1:       outReady = !rowCycle[0];
      2:       outReady = (rowCycle >= 8);
      default: outReady = 1'b1;
    endcase
  endtask

  task automatic sampleOutputs(input int r);
    logic [FlitWidth-1:0] expFlit;
    int                   p;
    int                   expPort;
    for (int q = 0; q < NumPorts; q++)
    begin
      if (inReady[q] !== (occ[q] < Depth))
      begin
        errors++;
        $display("ERR %s inReady[%0d] expected %0b actual %0b", testName[r], q,
                 occ[q] < Depth, inReady[q]);
      end
      if (inValid[q] && inReady[q])
      begin
        sent[q]++;
        occ[q]++;
      end
    end
    // Head of a stalled grant must not move
    if (outValid && prevStall && outPort == prevPort && {outFlitId, outData} !== prevFlit)
    begin
      errors++;
      $display("ERR %s stalled flit expected %h actual %h", testName[r], prevFlit,
               {outFlitId, outData});
    end
    if (outValid && outReady)
    begin
      p = int'(outPort);
      if (p >= NumPorts || recvd[p] >= flitCount[r][p])
      begin
        errors++;
        $display("%s: an unexpected extra flit left from port %0d", testName[r], p);
      end
      else
      begin
        expFlit = flits[p][recvd[p]];
        if ({outFlitId, outData} !== expFlit)
        begin
          errors++;
          $display("ERR %s flit expected %h actual %h", testName[r], expFlit,
                   {outFlitId, outData});
        end
        if (orderPos < expOrder[r].len())
        begin
          expPort = int'(expOrder[r][orderPos]) - 48;
          if (p != expPort)
          begin
            errors++;
            $display("ERR %s port expected %0d actual %0d", testName[r], expPort, p);
          end
        end
        orderPos++;
        recvd[p]++;
        occ[p]--;
      end
    end
    prevStall = outValid && !outReady;
    prevPort = outPort;
    prevFlit = {outFlitId, outData};
  endtask

  task automatic runRow(input int r);
    int total;
    total = 0;
    for (int p = 0; p < NumPorts; p++)
      total += flitCount[r][p];
    buildFlits(r);
    rowCycle = 0;
    orderPos = 0;
    prevStall = 1'b0;
    while (!allDone(r) && rowCycle < total * 20 + 20)
    begin
      @(posedge clk);
      #5;
      driveInputs(r);
      @(negedge clk);
      sampleOutputs(r);
      rowCycle++;
    end
    repeat (4) // Drained, so nothing more may leave
    begin
      @(posedge clk);
      #5;
      inValid = '0;
      outReady = 1'b1;
      @(negedge clk);
      sampleOutputs(r);
    end
    for (int p = 0; p < NumPorts; p++)
    begin
      if (recvd[p] < flitCount[r][p])
      begin
        errors++;
        $display("%s: %0d flits from port %0d never left the DUT", testName[r],
                 flitCount[r][p] - recvd[p], p);
      end
    end
  endtask

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b0;
    for (int p = 0; p < NumPorts; p++)
    begin
      inFlitId[p] = '0;
      inData[p] = '0;
    end
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;
    @(negedge clk);
    if (outValid !== 1'b0 || inReady !== '1)
    begin
      errors++;
      $display("After reset the output is valid or an input is not ready");
    end
    for (int r = 0; r < NumTests; r++)
      runRow(r);
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial
  begin : watchdog
    int total;
    total = 0;
    #1;
    for (int r = 0; r < NumTests; r++)
      for (int p = 0; p < NumPorts; p++)
        total += flitCount[r][p];
    #(total * 40 * 40); // 40 cycles per flit in the table
    $display("Watchdog expired before the tests finished");
    $display("Errors: %0d", errors);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/routerPkg.sv
logic/flitFifo.sv
logic/holdTimer.sv
logic/outputArbiter.sv
logic/outputPort.sv
verif/outputPortTb.sv

// File: run.sh
#!/bin/sh
# Build and run the output port testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module outputPortTb -Mdir build > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./build/VoutputPortTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0
